// ==== source/ps2_pkg.sv ====
package ps2_pkg;

    // ##################################################################
    // PS/2 frame layout
    // ##################################################################

    // one data byte as sent by the keyboard
    typedef logic [7:0] scan_code_t;

    // bit position inside a frame, 0 to 10
    typedef logic [3:0] bit_index_t;

    // start, 8 data bits LSB first, parity, stop
    // bit 0 = start bit, bit 10 = stop bit once the frame is complete
    typedef logic [10:0] frame_t;

    localparam bit_index_t LAST_BIT = 4'd10;

    // sent ahead of a released key's code
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

endpackage

// ==== source/display_pkg.sv ====
package display_pkg;

    // active low, bit 6 = segment a ... bit 0 = segment g
    typedef logic [6:0] seg_t;

    typedef logic [3:0] digit_t;

    // 0 to 99
    typedef logic [6:0] press_count_t;

    localparam seg_t SEG_BLANK = 7'b1111111;

    // hex glyphs 0-9, A, b, C, d, E, F
    localparam seg_t SEG_HEX [16] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
        7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
        7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
        7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000
    };

endpackage

// ==== source/ps2_frame_receiver.sv ====
module ps2_frame_receiver #(
    parameter int IDLE_LIMIT = 2000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                code_valid,
    output ps2_pkg::scan_code_t rx_code
);

    import ps2_pkg::*;

    localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);
    localparam logic [IDLE_W-1:0] IDLE_MAX = IDLE_W'(IDLE_LIMIT);

    // ##################################################################
    // synchronizers and edge detect
    // ##################################################################

    // two flops for metastability, third one for the edge
    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       ps2_fall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign ps2_fall = clk_sync[2] & ~clk_sync[1];

    // ##################################################################
    // frame assembly
    // ##################################################################

    frame_t            frame;
    frame_t            frame_next;
    bit_index_t        bit_idx;
    logic [IDLE_W-1:0] idle_cnt;
    logic              frame_ok;

    // shifted in from the top, so the start bit ends up in bit 0
    assign frame_next = {data_sync[1], frame[10:1]};

    // start 0, stop 1, odd parity over data plus parity bit
    assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

    always_ff @(posedge clk) begin
        if (ps2_fall) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_idx    <= '0;
            idle_cnt   <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (ps2_fall) begin
                idle_cnt <= '0;
            end else if (idle_cnt != IDLE_MAX) begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            if (ps2_fall) begin
                if (bit_idx == LAST_BIT) begin
                    bit_idx    <= '0;
                    code_valid <= frame_ok;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end else if (idle_cnt == IDLE_MAX) begin
                // line went quiet mid-frame
                bit_idx <= '0;
            end
        end
    end

    // stable until the next falling edge
    assign rx_code = frame[8:1];

endmodule

// ==== source/key_event_tracker.sv ====
module key_event_tracker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      code_valid,
    input  ps2_pkg::scan_code_t       rx_code,
    output logic                      push,
    output ps2_pkg::scan_code_t       push_code,
    output logic                      held,
    output display_pkg::press_count_t press_count
);

    import ps2_pkg::*;

    scan_code_t last_code;
    logic       break_pending;
    logic       new_press;

    // typematic repeats of the held key are not new presses
    assign new_press = !held || (rx_code != last_code);

    // ##################################################################
    // make / break decoding
    // ##################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            break_pending <= 1'b0;
            held          <= 1'b0;
            last_code     <= '0;
            push          <= 1'b0;
            press_count   <= '0;
        end else begin
            push <= 1'b0;
            if (code_valid) begin
                if (rx_code == BREAK_PREFIX) begin
                    break_pending <= 1'b1;
                end else if (break_pending) begin
                    break_pending <= 1'b0;
                    if (rx_code == last_code) begin
                        held <= 1'b0;
                    end
                end else if (new_press) begin
                    push      <= 1'b1;
                    last_code <= rx_code;
                    held      <= 1'b1;
                    // wraps 99 -> 0
                    if (press_count == 7'd99) begin
                        press_count <= '0;
                    end else begin
                        press_count <= press_count + 1'b1;
                    end
                end
            end
        end
    end

    // payload only, qualified by push
    always_ff @(posedge clk) begin
        if (code_valid) begin
            push_code <= rx_code;
        end
    end

endmodule

// ==== source/scan_code_fifo.sv ====
module scan_code_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                next_n,
    input  ps2_pkg::scan_code_t push_code,
    output ps2_pkg::scan_code_t head_code,
    output logic                ready,
    output logic                overflow
);

    import ps2_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    scan_code_t mem [FIFO_DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        pop;
    logic        wr_en;

    assign ready = (wr_ptr != rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // next_n is a level request, one entry per cycle
    assign pop   = !next_n && ready;
    assign wr_en = push && !full;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= push_code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assign head_code = mem[rd_ptr[AW-1:0]];

endmodule

// ==== source/segment_display.sv ====
module segment_display (
    input  ps2_pkg::scan_code_t       head_code,
    input  logic                      ready,
    input  logic                      held,
    input  display_pkg::press_count_t press_count,
    output display_pkg::seg_t         seg0,
    output display_pkg::seg_t         seg1,
    output display_pkg::seg_t         seg2,
    output display_pkg::seg_t         seg3,
    output display_pkg::seg_t         seg4,
    output display_pkg::seg_t         seg5
);

    import ps2_pkg::*;
    import display_pkg::*;

    scan_code_t ascii_code;
    logic       is_digit_key;
    logic       show_code;
    digit_t     ones;
    digit_t     tens;

    // ##################################################################
    // digit-key scan codes to ASCII
    // ##################################################################

    always_comb begin
        is_digit_key = 1'b1;
        case (head_code)
            8'h45: ascii_code = 8'h30;
            8'h16: ascii_code = 8'h31;
            8'h1E: ascii_code = 8'h32;
            8'h26: ascii_code = 8'h33;
            8'h25: ascii_code = 8'h34;
            8'h2E: ascii_code = 8'h35;
            8'h36: ascii_code = 8'h36;
            8'h3D: ascii_code = 8'h37;
            8'h3E: ascii_code = 8'h38;
            8'h46: ascii_code = 8'h39;
            default: begin
                ascii_code   = 8'h00;
                is_digit_key = 1'b0;
            end
        endcase
    end

    // code digits only while a key is down and the fifo has something
    assign show_code = ready && held;

    always_comb begin
        if (show_code) begin
            seg0 = SEG_HEX[head_code[3:0]];
            seg1 = SEG_HEX[head_code[7:4]];
        end else begin
            seg0 = SEG_BLANK;
            seg1 = SEG_BLANK;
        end
    end

    always_comb begin
        if (show_code && is_digit_key) begin
            seg2 = SEG_HEX[ascii_code[3:0]];
            seg3 = SEG_HEX[ascii_code[7:4]];
        end else begin
            seg2 = SEG_BLANK;
            seg3 = SEG_BLANK;
        end
    end

    // ##################################################################
    // press count, decimal
    // ##################################################################

    assign ones = digit_t'(press_count % 7'd10);
    assign tens = digit_t'(press_count / 7'd10);

    assign seg4 = SEG_HEX[ones];
    assign seg5 = SEG_HEX[tens];

endmodule

// ==== source/ps2_keyboard_top.sv ====
module ps2_keyboard_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int IDLE_LIMIT = 2000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                next_n,
    output ps2_pkg::scan_code_t code,
    output logic                ready,
    output logic                overflow,
    output display_pkg::seg_t   seg0,
    output display_pkg::seg_t   seg1,
    output display_pkg::seg_t   seg2,
    output display_pkg::seg_t   seg3,
    output display_pkg::seg_t   seg4,
    output display_pkg::seg_t   seg5
);

    import ps2_pkg::*;
    import display_pkg::*;

    logic         code_valid;
    scan_code_t   rx_code;
    logic         push;
    scan_code_t   push_code;
    logic         held;
    press_count_t press_count;

    ps2_frame_receiver #(
        .IDLE_LIMIT (IDLE_LIMIT)
    ) receiver0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code_valid (code_valid),
        .rx_code    (rx_code)
    );

    key_event_tracker tracker0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .code_valid  (code_valid),
        .rx_code     (rx_code),
        .push        (push),
        .push_code   (push_code),
        .held        (held),
        .press_count (press_count)
    );

    scan_code_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .next_n    (next_n),
        .push_code (push_code),
        .head_code (code),
        .ready     (ready),
        .overflow  (overflow)
    );

    segment_display display0 (
        .head_code   (code),
        .ready       (ready),
        .held        (held),
        .press_count (press_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

endmodule

// ==== dv/ps2_keyboard_tb.sv ====
module ps2_keyboard_tb;

    localparam int HALF        = 20;
    localparam int SETTLE      = 10;
    localparam int CYCLE_LIMIT = 180000;
    localparam logic [4:0] BLANK = 5'd16;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       next_n;
    logic [7:0] code;
    logic       ready;
    logic       overflow;
    logic [6:0] seg0, seg1, seg2, seg3, seg4, seg5;

    // reference model
    logic [7:0] exp_q [$];
    logic [7:0] m_last;
    logic       m_held;
    logic       m_brk;
    // press count as two decimal digits
    logic [3:0] m_ones;
    logic [3:0] m_tens;
    logic       exp_overflow;
    logic       exp_ready;
    logic [7:0] exp_code;
    logic [4:0] exp_d0, exp_d1, exp_d2, exp_d3, exp_d4, exp_d5;

    logic        check_en;
    logic [31:0] rng_state;
    logic [7:0]  rand_code;
    int          cycle_count = 0;
    int          error_count = 0;
    int          errors_at_start;
    int          pass_count = 0;
    int          fail_count = 0;
    string       current_test;

    ps2_keyboard_top #(
        .FIFO_DEPTH (8),
        .IDLE_LIMIT (200)
    ) dut0 (
        .clk (clk), .rst_n (rst_n), .ps2_clk (ps2_clk), .ps2_data (ps2_data),
        .next_n (next_n), .code (code), .ready (ready), .overflow (overflow),
        .seg0 (seg0), .seg1 (seg1), .seg2 (seg2), .seg3 (seg3), .seg4 (seg4), .seg5 (seg5)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // ####################################################################
    // model helpers
    // ####################################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // active-low abcdefg back to a digit, 16 = blank, 31 = garbage
    function automatic logic [4:0] seg_digit(input logic [6:0] s);
        case (s)
            7'b0000001: return 5'd0;
            7'b1001111: return 5'd1;
            7'b0010010: return 5'd2;
            7'b0000110: return 5'd3;
            7'b1001100: return 5'd4;
            7'b0100100: return 5'd5;
            7'b0100000: return 5'd6;
            7'b0001111: return 5'd7;
            7'b0000000: return 5'd8;
            7'b0000100: return 5'd9;
            7'b0001000: return 5'd10;
            7'b1100000: return 5'd11;
            7'b0110001: return 5'd12;
            7'b1000010: return 5'd13;
            7'b0110000: return 5'd14;
            7'b0111000: return 5'd15;
            7'b1111111: return BLANK;
            default:    return 5'd31;
        endcase
    endfunction

    // 0 means not a digit key
    function automatic logic [7:0] key_ascii(input logic [7:0] c);
        case (c)
            8'h45: return 8'h30;
            8'h16: return 8'h31;
            8'h1E: return 8'h32;
            8'h26: return 8'h33;
            8'h25: return 8'h34;
            8'h2E: return 8'h35;
            8'h36: return 8'h36;
            8'h3D: return 8'h37;
            8'h3E: return 8'h38;
            8'h46: return 8'h39;
            default: return 8'h00;
        endcase
    endfunction

    task automatic apply_code(input logic [7:0] c);
        if (c == 8'hF0) begin
            m_brk = 1'b1;
        end else if (m_brk) begin
            m_brk = 1'b0;
            if (c == m_last) m_held = 1'b0;
        end else if (!m_held || c != m_last) begin
            if (exp_q.size() < 8) exp_q.push_back(c);
            else exp_overflow = 1'b1;
            m_last  = c;
            m_held  = 1'b1;
            // decimal carry, 99 rolls over to 00
            if (m_ones == 4'd9) begin
                m_ones = 4'd0;
                m_tens = (m_tens == 4'd9) ? 4'd0 : m_tens + 4'd1;
            end else begin
                m_ones = m_ones + 4'd1;
            end
        end
    endtask

    task automatic refresh_expected();
        logic       show;
        logic [7:0] asc;
        exp_ready = (exp_q.size() != 0);
        exp_code  = exp_ready ? exp_q[0] : 8'h00;
        show      = exp_ready && m_held;
        asc       = key_ascii(exp_code);
        exp_d0    = show ? {1'b0, exp_code[3:0]} : BLANK;
        exp_d1    = show ? {1'b0, exp_code[7:4]} : BLANK;
        exp_d2    = (show && asc != 8'h00) ? {1'b0, asc[3:0]} : BLANK;
        exp_d3    = (show && asc != 8'h00) ? {1'b0, asc[7:4]} : BLANK;
        exp_d4    = {1'b0, m_ones};
        exp_d5    = {1'b0, m_tens};
    endtask

    // ####################################################################
    // stimulus
    // ####################################################################

    task automatic settle();
        repeat (SETTLE) @(posedge clk);
        check_en = 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, ~(^data) ^ bad_parity, data, 1'b0};
        check_en = 1'b0;
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (HALF) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_data <= 1'b1;
        if (!bad_parity && !bad_stop) apply_code(data);
        refresh_expected();
        settle();
    endtask

    task automatic release_key(input logic [7:0] c);
        send_frame(8'hF0, 1'b0, 1'b0);
        send_frame(c, 1'b0, 1'b0);
    endtask

    task automatic pop_head();
        check_en = 1'b0;
        next_n <= 1'b0;
        @(posedge clk);
        next_n <= 1'b1;
        if (exp_q.size() > 0) exp_q.delete(0);
        refresh_expected();
        settle();
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] expected);
        error_count++;
        $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, expected);
    endtask

    task automatic begin_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", current_test);
        end else begin
            fail_count++;
            $display("test %s: %0d mismatches", current_test, error_count - errors_at_start);
        end
    endtask

    // ####################################################################
    // checks while the DUT is idle
    // ####################################################################

    assert property (@(posedge clk) disable iff (!check_en) ready == exp_ready)
        else report_mismatch("ready", 8'(ready), 8'(exp_ready));
    assert property (@(posedge clk) disable iff (!check_en) !exp_ready || code == exp_code)
        else report_mismatch("code", code, exp_code);
    assert property (@(posedge clk) disable iff (!check_en) overflow == exp_overflow)
        else report_mismatch("overflow", 8'(overflow), 8'(exp_overflow));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg0) == exp_d0)
        else report_mismatch("seg0", 8'(seg_digit(seg0)), 8'(exp_d0));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg1) == exp_d1)
        else report_mismatch("seg1", 8'(seg_digit(seg1)), 8'(exp_d1));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg2) == exp_d2)
        else report_mismatch("seg2", 8'(seg_digit(seg2)), 8'(exp_d2));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg3) == exp_d3)
        else report_mismatch("seg3", 8'(seg_digit(seg3)), 8'(exp_d3));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg4) == exp_d4)
        else report_mismatch("seg4", 8'(seg_digit(seg4)), 8'(exp_d4));
    assert property (@(posedge clk) disable iff (!check_en) seg_digit(seg5) == exp_d5)
        else report_mismatch("seg5", 8'(seg_digit(seg5)), 8'(exp_d5));

    initial begin
        rst_n        = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        next_n       = 1'b1;
        check_en     = 1'b0;
        rng_state    = 32'd99;
        m_last       = 8'h00;
        m_held       = 1'b0;
        m_brk        = 1'b0;
        m_ones       = 4'd0;
        m_tens       = 4'd0;
        exp_overflow = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        refresh_expected();
        settle();

        begin_test("single digit key");
        send_frame(8'h16, 1'b0, 1'b0);
        end_test();

        begin_test("release");
        release_key(8'h16);
        pop_head();
        end_test();

        begin_test("typematic repeat");
        repeat (4) send_frame(8'h1C, 1'b0, 1'b0);
        send_frame(8'h1B, 1'b0, 1'b0);
        release_key(8'h1B);
        release_key(8'h1C);
        repeat (2) pop_head();
        end_test();

        begin_test("bad frames");
        send_frame(8'h29, 1'b1, 1'b0);
        send_frame(8'h29, 1'b0, 1'b1);
        send_frame(8'h29, 1'b0, 1'b0);
        release_key(8'h29);
        pop_head();
        end_test();

        begin_test("overflow");
        send_frame(8'h15, 1'b0, 1'b0);
        send_frame(8'h1D, 1'b0, 1'b0);
        send_frame(8'h24, 1'b0, 1'b0);
        send_frame(8'h2D, 1'b0, 1'b0);
        send_frame(8'h2C, 1'b0, 1'b0);
        send_frame(8'h35, 1'b0, 1'b0);
        send_frame(8'h3C, 1'b0, 1'b0);
        send_frame(8'h43, 1'b0, 1'b0);
        send_frame(8'h44, 1'b0, 1'b0);
        send_frame(8'h4D, 1'b0, 1'b0);
        repeat (8) pop_head();
        release_key(8'h4D);
        end_test();

        begin_test("random presses");
        for (int i = 0; i < 105; i++) begin
            rng_state = xorshift(rng_state);
            rand_code = rng_state[7:0];
            if (rand_code == 8'hF0) rand_code = 8'h0F;
            send_frame(rand_code, 1'b0, 1'b0);
            pop_head();
            release_key(rand_code);
        end
        end_test();

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/ps2_pkg.sv
source/display_pkg.sv
source/ps2_frame_receiver.sv
source/key_event_tracker.sv
source/scan_code_fifo.sv
source/segment_display.sv
source/ps2_keyboard_top.sv
dv/ps2_keyboard_tb.sv

// ==== Makefile ====
# Verilator build and run for the PS/2 keyboard project

VERILATOR ?= verilator
TOP       ?= ps2_keyboard_tb
RTL_TOP   ?= ps2_keyboard_top
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing --assert

SOURCES := $(wildcard source/*.sv dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
